//--- hw/mem_defs.svh
`ifndef MEM_DEFS_SVH
`define MEM_DEFS_SVH

// one memory word, also the operand width
`define MEM_DATA_W 64

// word address, memory holds 2**MEM_ADDR_W words
`define MEM_ADDR_W 8

// rep iteration count
`define MEM_CNT_W 16

// instruction pointer
`define EIP_W 32

`endif

//--- hw/mem_pkg.sv
`default_nettype none

package mem_pkg;

`include "mem_defs.svh"

    typedef logic [`MEM_DATA_W-1:0] word_t;
    typedef logic [`MEM_ADDR_W-1:0] waddr_t;
    typedef logic [`MEM_CNT_W-1:0]  rep_cnt_t;
    typedef logic [`EIP_W-1:0]      eip_t;

    // operand source codes, 6 and 7 are unused
    typedef enum logic [2:0] {
        SRC_REG1 = 3'd0,
        SRC_REG2 = 3'd1,
        SRC_MEM1 = 3'd2,
        SRC_MEM2 = 3'd3,
        SRC_IMM  = 3'd4,
        SRC_EIP  = 3'd5
    } opnd_src_t;

    typedef enum logic [1:0] {PORT_IDLE, PORT_REQ, PORT_DATA, PORT_DONE} port_state_t;

    typedef enum logic [1:0] {ST_IDLE, ST_ACCESS, ST_OUT} stage_state_t;

endpackage

`default_nettype wire

//--- hw/rep_addr_gen.sv
`timescale 1ns/1ps
`default_nettype none

module rep_addr_gen
    import mem_pkg::*;
(
    input  logic     clk,
    input  logic     arst_n,
    input  logic     load,
    input  logic     step,
    input  logic     is_rep,
    input  logic     dir_dec,
    input  waddr_t   addr1_in,
    input  waddr_t   addr2_in,
    input  rep_cnt_t count_in,
    output waddr_t   addr1,
    output waddr_t   addr2,
    output logic     last
);

    waddr_t   addr1_q;
    waddr_t   addr2_q;
    rep_cnt_t cnt_q;
    logic     dec_q;
    rep_cnt_t load_cnt;
    waddr_t   delta;

    // non-rep and a zero count both mean a single iteration
    always_comb begin
        if (is_rep && (count_in != '0)) begin
            load_cnt = count_in;
        end else begin
            load_cnt = rep_cnt_t'(1);
        end
    end

    // +1 or -1 in two's complement, wraps at the memory depth
    assign delta = dec_q ? '1 : waddr_t'(1);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            addr1_q <= '0;
            addr2_q <= '0;
            cnt_q   <= '0;
            dec_q   <= 1'b0;
        end else if (load) begin
            addr1_q <= addr1_in;
            addr2_q <= addr2_in;
            cnt_q   <= load_cnt;
            // direction flag is held for the whole instruction
            dec_q   <= dir_dec;
        end else if (step) begin
            addr1_q <= addr1_q + delta;
            addr2_q <= addr2_q + delta;
            cnt_q   <= cnt_q - rep_cnt_t'(1);
        end
    end

    assign addr1 = addr1_q;
    assign addr2 = addr2_q;
    assign last  = (cnt_q == rep_cnt_t'(1));

endmodule

`default_nettype wire

//--- hw/mem_read_port.sv
`timescale 1ns/1ps
`default_nettype none

module mem_read_port
    import mem_pkg::*;
(
    input  logic   clk,
    input  logic   arst_n,
    input  logic   start,
    input  logic   rd_en,
    input  waddr_t addr_in,
    input  logic   grant,
    input  word_t  rdata,
    output logic   req,
    output waddr_t req_addr,
    output word_t  data,
    output logic   done
);

    port_state_t state;
    waddr_t      addr_q;
    word_t       data_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= PORT_IDLE;
        end else if (start) begin
            // a disabled read finishes right away
            state <= rd_en ? PORT_REQ : PORT_DONE;
        end else begin
            case (state)
                PORT_REQ: begin
                    if (grant) begin
                        state <= PORT_DATA;
                    end
                end
                PORT_DATA: begin
                    state <= PORT_DONE;
                end
                // idle and done hold until the next start
                default: begin
                    state <= state;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            addr_q <= addr_in;
        end
    end

    // ram output is valid during the data cycle
    always_ff @(posedge clk) begin
        if (start && !rd_en) begin
            data_q <= '0;
        end else if (state == PORT_DATA) begin
            data_q <= rdata;
        end
    end

    assign req      = (state == PORT_REQ);
    assign req_addr = addr_q;
    assign data     = data_q;
    assign done     = (state == PORT_DONE);

endmodule

`default_nettype wire

//--- hw/mem_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module mem_arbiter
    import mem_pkg::*;
(
    input  logic   clk,
    input  logic   arst_n,
    input  logic   wb_valid,
    input  waddr_t wb_addr,
    input  word_t  wb_data,
    input  logic   req1,
    input  logic   req2,
    input  waddr_t addr1,
    input  waddr_t addr2,
    output logic   wb_full,
    output logic   grant1,
    output logic   grant2,
    output logic   mem_we,
    output waddr_t mem_addr,
    output word_t  mem_wdata
);

    logic   wb_full_q;
    waddr_t wb_addr_q;
    word_t  wb_data_q;
    // set when port 2 got the last grant
    logic   last2_q;

    // the held write drains in its first full cycle, it always wins the port
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wb_full_q <= 1'b0;
        end else if (wb_full_q) begin
            wb_full_q <= 1'b0;
        end else if (wb_valid) begin
            wb_full_q <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (wb_valid && !wb_full_q) begin
            wb_addr_q <= wb_addr;
            wb_data_q <= wb_data;
        end
    end

    // readers alternate when both request
    assign grant1 = !wb_full_q && req1 && (!req2 || last2_q);
    assign grant2 = !wb_full_q && req2 && (!req1 || !last2_q);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            last2_q <= 1'b1;
        end else if (grant1 || grant2) begin
            last2_q <= grant2;
        end
    end

    always_comb begin
        if (wb_full_q) begin
            mem_addr = wb_addr_q;
        end else if (grant2) begin
            mem_addr = addr2;
        end else begin
            mem_addr = addr1;
        end
    end

    assign mem_we    = wb_full_q;
    assign mem_wdata = wb_data_q;
    assign wb_full   = wb_full_q;

endmodule

`default_nettype wire

//--- hw/data_mem.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_defs.svh"

module data_mem
    import mem_pkg::*;
(
    input  logic   clk,
    input  logic   we,
    input  waddr_t addr,
    input  word_t  wdata,
    output word_t  rdata
);

    localparam int DEPTH = 2 ** `MEM_ADDR_W;

    word_t mem [0:DEPTH-1];
    word_t rdata_q;

    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
    end

    // registered read, old data on a same-cycle write
    always_ff @(posedge clk) begin
        rdata_q <= mem[addr];
    end

    assign rdata = rdata_q;

endmodule

`default_nettype wire

//--- hw/operand_select.sv
`timescale 1ns/1ps
`default_nettype none

module operand_select
    import mem_pkg::*;
(
    input  opnd_src_t sel1,
    input  opnd_src_t sel2,
    input  word_t     reg1,
    input  word_t     reg2,
    input  word_t     mem1,
    input  word_t     mem2,
    input  word_t     imm,
    input  eip_t      eip,
    output word_t     op1,
    output word_t     op2
);

    word_t eip_ext;

    // eip is unsigned, so the cast fills with zeros
    assign eip_ext = word_t'(eip);

    function automatic word_t pick(
        input opnd_src_t sel,
        input word_t     r1,
        input word_t     r2,
        input word_t     m1,
        input word_t     m2,
        input word_t     im,
        input word_t     ip
    );
        word_t val;
        case (sel)
            SRC_REG1: val = r1;
            SRC_REG2: val = r2;
            SRC_MEM1: val = m1;
            SRC_MEM2: val = m2;
            SRC_IMM:  val = im;
            SRC_EIP:  val = ip;
            default:  val = '0;
        endcase
        return val;
    endfunction

    assign op1 = pick(sel1, reg1, reg2, mem1, mem2, imm, eip_ext);
    assign op2 = pick(sel2, reg1, reg2, mem1, mem2, imm, eip_ext);

endmodule

`default_nettype wire

//--- hw/mem_stage.sv
`timescale 1ns/1ps
`default_nettype none

module mem_stage
    import mem_pkg::*;
(
    input  logic      clk,
    input  logic      arst_n,
    input  logic      valid_in,
    input  logic      is_rep_in,
    input  logic      dir_dec_in,
    input  logic      mem1_rd,
    input  logic      mem2_rd,
    input  waddr_t    mem_addr1,
    input  waddr_t    mem_addr2,
    input  rep_cnt_t  rep_count,
    input  word_t     reg1,
    input  word_t     reg2,
    input  word_t     imm,
    input  eip_t      eip_in,
    input  opnd_src_t op1_sel,
    input  opnd_src_t op2_sel,
    input  logic      wb_valid,
    input  waddr_t    wb_addr,
    input  word_t     wb_data,
    output logic      wb_full,
    output logic      valid_out,
    output word_t     op1_val,
    output word_t     op2_val,
    output waddr_t    mem1_addr_out,
    output waddr_t    mem2_addr_out,
    output eip_t      eip_out,
    output logic      stall
);

    stage_state_t state;
    logic      accept;
    logic      start_q;
    logic      step;
    logic      last;
    logic      mem1_rd_q;
    logic      mem2_rd_q;
    opnd_src_t op1_sel_q;
    opnd_src_t op2_sel_q;
    word_t     reg1_q;
    word_t     reg2_q;
    word_t     imm_q;
    eip_t      eip_q;
    waddr_t    cur_addr1;
    waddr_t    cur_addr2;
    logic      p1_req;
    logic      p2_req;
    waddr_t    p1_addr;
    waddr_t    p2_addr;
    word_t     p1_data;
    word_t     p2_data;
    logic      p1_done;
    logic      p2_done;
    logic      grant1;
    logic      grant2;
    logic      mem_we;
    waddr_t    mem_addr;
    word_t     mem_wdata;
    word_t     mem_rdata;

    // stall drops during the last output cycle so the next instruction overlaps it
    assign stall     = (state == ST_ACCESS) || ((state == ST_OUT) && !last);
    assign accept    = valid_in && !stall;
    assign step      = (state == ST_OUT) && !last;
    assign valid_out = (state == ST_OUT);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state     <= ST_IDLE;
            start_q   <= 1'b0;
            mem1_rd_q <= 1'b0;
            mem2_rd_q <= 1'b0;
            op1_sel_q <= SRC_REG1;
            op2_sel_q <= SRC_REG1;
        end else begin
            // ports start one cycle after load or step, once addresses settle
            start_q <= accept || step;
            if (accept) begin
                mem1_rd_q <= mem1_rd;
                mem2_rd_q <= mem2_rd;
                op1_sel_q <= op1_sel;
                op2_sel_q <= op2_sel;
            end
            case (state)
                ST_IDLE: begin
                    if (accept) begin
                        state <= ST_ACCESS;
                    end
                end
                ST_ACCESS: begin
                    // done levels are stale in the start cycle
                    if (!start_q && p1_done && p2_done) begin
                        state <= ST_OUT;
                    end
                end
                ST_OUT: begin
                    state <= (!last || accept) ? ST_ACCESS : ST_IDLE;
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            reg1_q <= reg1;
            reg2_q <= reg2;
            imm_q  <= imm;
            eip_q  <= eip_in;
        end
    end

    rep_addr_gen i_rep_addr_gen (
        .clk      (clk),
        .arst_n   (arst_n),
        .load     (accept),
        .step     (step),
        .is_rep   (is_rep_in),
        .dir_dec  (dir_dec_in),
        .addr1_in (mem_addr1),
        .addr2_in (mem_addr2),
        .count_in (rep_count),
        .addr1    (cur_addr1),
        .addr2    (cur_addr2),
        .last     (last)
    );

    mem_read_port port1 (
        .clk      (clk),
        .arst_n   (arst_n),
        .start    (start_q),
        .rd_en    (mem1_rd_q),
        .addr_in  (cur_addr1),
        .grant    (grant1),
        .rdata    (mem_rdata),
        .req      (p1_req),
        .req_addr (p1_addr),
        .data     (p1_data),
        .done     (p1_done)
    );

    mem_read_port port2 (
        .clk      (clk),
        .arst_n   (arst_n),
        .start    (start_q),
        .rd_en    (mem2_rd_q),
        .addr_in  (cur_addr2),
        .grant    (grant2),
        .rdata    (mem_rdata),
        .req      (p2_req),
        .req_addr (p2_addr),
        .data     (p2_data),
        .done     (p2_done)
    );

    mem_arbiter i_mem_arbiter (
        .clk       (clk),
        .arst_n    (arst_n),
        .wb_valid  (wb_valid),
        .wb_addr   (wb_addr),
        .wb_data   (wb_data),
        .req1      (p1_req),
        .req2      (p2_req),
        .addr1     (p1_addr),
        .addr2     (p2_addr),
        .wb_full   (wb_full),
        .grant1    (grant1),
        .grant2    (grant2),
        .mem_we    (mem_we),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata)
    );

    data_mem i_data_mem (
        .clk   (clk),
        .we    (mem_we),
        .addr  (mem_addr),
        .wdata (mem_wdata),
        .rdata (mem_rdata)
    );

    operand_select i_operand_select (
        .sel1 (op1_sel_q),
        .sel2 (op2_sel_q),
        .reg1 (reg1_q),
        .reg2 (reg2_q),
        .mem1 (p1_data),
        .mem2 (p2_data),
        .imm  (imm_q),
        .eip  (eip_q),
        .op1  (op1_val),
        .op2  (op2_val)
    );

    // addresses of the iteration being presented
    assign mem1_addr_out = cur_addr1;
    assign mem2_addr_out = cur_addr2;
    assign eip_out       = eip_q;

endmodule

`default_nettype wire

//--- test/tb_mem_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_defs.svh"

module tb_mem_stage
    import mem_pkg::*;
();

    localparam int DEPTH      = 2 ** `MEM_ADDR_W;
    localparam int WAIT_LIMIT = 1000;
    localparam int OUT_LIMIT  = 5000;

    logic      clk;
    logic      arst_n;
    logic      valid_in;
    logic      is_rep_in;
    logic      dir_dec_in;
    logic      mem1_rd;
    logic      mem2_rd;
    waddr_t    mem_addr1;
    waddr_t    mem_addr2;
    rep_cnt_t  rep_count;
    word_t     reg1;
    word_t     reg2;
    word_t     imm;
    eip_t      eip_in;
    opnd_src_t op1_sel;
    opnd_src_t op2_sel;
    logic      wb_valid;
    waddr_t    wb_addr;
    word_t     wb_data;
    logic      wb_full;
    logic      valid_out;
    word_t     op1_val;
    word_t     op2_val;
    waddr_t    mem1_addr_out;
    waddr_t    mem2_addr_out;
    eip_t      eip_out;
    logic      stall;

    logic [31:0] lfsr_q;
    word_t       shadow [0:DEPTH-1];
    word_t       exp_op1_q [$];
    word_t       exp_op2_q [$];
    waddr_t      exp_a1_q [$];
    waddr_t      exp_a2_q [$];
    eip_t        exp_eip_q [$];
    int          out_count;
    int          expected_total;
    string       test_name;

    mem_stage i_mem_stage (
        .clk           (clk),
        .arst_n        (arst_n),
        .valid_in      (valid_in),
        .is_rep_in     (is_rep_in),
        .dir_dec_in    (dir_dec_in),
        .mem1_rd       (mem1_rd),
        .mem2_rd       (mem2_rd),
        .mem_addr1     (mem_addr1),
        .mem_addr2     (mem_addr2),
        .rep_count     (rep_count),
        .reg1          (reg1),
        .reg2          (reg2),
        .imm           (imm),
        .eip_in        (eip_in),
        .op1_sel       (op1_sel),
        .op2_sel       (op2_sel),
        .wb_valid      (wb_valid),
        .wb_addr       (wb_addr),
        .wb_data       (wb_data),
        .wb_full       (wb_full),
        .valid_out     (valid_out),
        .op1_val       (op1_val),
        .op2_val       (op2_val),
        .mem1_addr_out (mem1_addr_out),
        .mem2_addr_out (mem2_addr_out),
        .eip_out       (eip_out),
        .stall         (stall)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // galois form with taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    // one lfsr step per bit taken
    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_step(lfsr_q);
            val    = {val[62:0], lfsr_q[0]};
        end
        return val;
    endfunction

    // uniform in lo..hi by redrawing when the bits overshoot
    function automatic int rand_range(input int lo, input int hi, input int bits);
        int v;
        v = int'(rand_bits(bits));
        while (v > hi - lo) begin
            v = int'(rand_bits(bits));
        end
        return lo + v;
    endfunction

    function automatic opnd_src_t rand_sel();
        return opnd_src_t'(3'(rand_range(0, 5, 3)));
    endfunction

    task automatic stop_with_error(input string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic check_value(input string what, input logic [63:0] exp,
                               input logic [63:0] act);
        if (exp !== act) begin
            stop_with_error($sformatf("error: %s %s expected %h actual %h",
                                      test_name, what, exp, act));
        end
    endtask

    function automatic word_t source_value(input opnd_src_t sel, input word_t r1,
                                           input word_t r2, input word_t m1,
                                           input word_t m2, input word_t im,
                                           input eip_t ip);
        case (sel)
            SRC_REG1: return r1;
            SRC_REG2: return r2;
            SRC_MEM1: return m1;
            SRC_MEM2: return m2;
            SRC_IMM:  return im;
            SRC_EIP:  return {{(`MEM_DATA_W - `EIP_W){1'b0}}, ip};
            default:  return '0;
        endcase
    endfunction

    // expected addresses and operands for iteration k of one instruction
    function automatic void expect_iter(input logic rd1, input logic rd2, input logic dec,
                                        input waddr_t a1, input waddr_t a2,
                                        input opnd_src_t s1, input opnd_src_t s2,
                                        input word_t r1, input word_t r2, input word_t im,
                                        input eip_t ip, input int k,
                                        output waddr_t e_a1, output waddr_t e_a2,
                                        output word_t e_op1, output word_t e_op2);
        word_t m1;
        word_t m2;
        e_a1  = dec ? a1 - waddr_t'(k) : a1 + waddr_t'(k);
        e_a2  = dec ? a2 - waddr_t'(k) : a2 + waddr_t'(k);
        m1    = rd1 ? shadow[e_a1] : '0;
        m2    = rd2 ? shadow[e_a2] : '0;
        e_op1 = source_value(s1, r1, r2, m1, m2, im, ip);
        e_op2 = source_value(s2, r1, r2, m1, m2, im, ip);
    endfunction

    task automatic wait_stall_low();
        int n;
        n = 0;
        while (stall) begin
            if (n == WAIT_LIMIT) begin
                stop_with_error("timeout: stall stayed high");
            end
            @(negedge clk);
            n++;
        end
    endtask

    task automatic wait_wb_free();
        int n;
        n = 0;
        while (wb_full) begin
            if (n == WAIT_LIMIT) begin
                stop_with_error("timeout: writeback never drained, wb_full stayed high");
            end
            @(negedge clk);
            n++;
        end
    endtask

    task automatic wait_outputs();
        int n;
        n = 0;
        while (out_count < expected_total) begin
            if (n == OUT_LIMIT) begin
                stop_with_error("timeout: too few valid_out pulses");
            end
            @(negedge clk);
            n++;
        end
    endtask

    task automatic send_write(input waddr_t addr, input word_t data);
        wait_wb_free();
        wb_valid     = 1'b1;
        wb_addr      = addr;
        wb_data      = data;
        shadow[addr] = data;
        @(negedge clk);
        wb_valid = 1'b0;
    endtask

    task automatic issue_instr(input logic rep, input logic dec, input logic rd1,
                               input logic rd2, input waddr_t a1, input waddr_t a2,
                               input rep_cnt_t cnt, input opnd_src_t s1,
                               input opnd_src_t s2);
        word_t  r1;
        word_t  r2;
        word_t  im;
        eip_t   ip;
        int     n_iter;
        waddr_t e_a1;
        waddr_t e_a2;
        word_t  e_op1;
        word_t  e_op2;
        r1 = rand_bits(64);
        r2 = rand_bits(64);
        im = rand_bits(64);
        ip = eip_t'(rand_bits(32));
        // zero count behaves like a single pass
        n_iter = (rep && cnt != 0) ? int'(cnt) : 1;
        for (int k = 0; k < n_iter; k++) begin
            expect_iter(rd1, rd2, dec, a1, a2, s1, s2, r1, r2, im, ip, k,
                        e_a1, e_a2, e_op1, e_op2);
            exp_op1_q.push_back(e_op1);
            exp_op2_q.push_back(e_op2);
            exp_a1_q.push_back(e_a1);
            exp_a2_q.push_back(e_a2);
            exp_eip_q.push_back(ip);
        end
        expected_total += n_iter;
        wait_stall_low();
        is_rep_in  = rep;
        dir_dec_in = dec;
        mem1_rd    = rd1;
        mem2_rd    = rd2;
        mem_addr1  = a1;
        mem_addr2  = a2;
        rep_count  = cnt;
        reg1       = r1;
        reg2       = r2;
        imm        = im;
        eip_in     = ip;
        op1_sel    = s1;
        op2_sel    = s2;
        valid_in   = 1'b1;
        @(negedge clk);
        valid_in = 1'b0;
    endtask

    // compares every output pulse against the oldest expected iteration
    initial begin
        out_count = 0;
        forever begin
            @(posedge clk);
            if (valid_out && exp_op1_q.size() == 0) begin
                stop_with_error("valid_out pulse arrived with no instruction outstanding");
            end else if (valid_out) begin
                check_value("op1_val", exp_op1_q.pop_front(), op1_val);
                check_value("op2_val", exp_op2_q.pop_front(), op2_val);
                check_value("mem1_addr_out", 64'(exp_a1_q.pop_front()), 64'(mem1_addr_out));
                check_value("mem2_addr_out", 64'(exp_a2_q.pop_front()), 64'(mem2_addr_out));
                check_value("eip_out", 64'(exp_eip_q.pop_front()), 64'(eip_out));
                out_count++;
            end
        end
    end

    initial begin
        waddr_t   a1;
        waddr_t   a2;
        rep_cnt_t cnt;
        logic     dec;
        logic     rd1;
        logic     rd2;
        opnd_src_t s1;
        opnd_src_t s2;
        lfsr_q         = 32'hbe7004e8;
        expected_total = 0;
        test_name      = "reset";
        arst_n     = 1'b0;
        valid_in   = 1'b0;
        is_rep_in  = 1'b0;
        dir_dec_in = 1'b0;
        mem1_rd    = 1'b0;
        mem2_rd    = 1'b0;
        mem_addr1  = '0;
        mem_addr2  = '0;
        rep_count  = '0;
        reg1       = '0;
        reg2       = '0;
        imm        = '0;
        eip_in     = '0;
        op1_sel    = SRC_REG1;
        op2_sel    = SRC_REG1;
        wb_valid   = 1'b0;
        wb_addr    = '0;
        wb_data    = '0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        @(negedge clk);
        check_value("valid_out", 64'(0), 64'(valid_out));
        check_value("stall", 64'(0), 64'(stall));
        check_value("wb_full", 64'(0), 64'(wb_full));

        // fill the whole memory so every later read has a known word
        test_name = "writeback_read";
        for (int a = 0; a < DEPTH; a++) begin
            send_write(waddr_t'(a), rand_bits(64));
        end
        wait_wb_free();
        for (int i = 0; i < 20; i++) begin
            a1 = waddr_t'(rand_bits(8));
            a2 = waddr_t'(rand_bits(8));
            issue_instr(1'b0, 1'b0, 1'b1, 1'b1, a1, a2, '0, SRC_MEM1, SRC_MEM2);
        end
        wait_outputs();

        test_name = "operand_select";
        for (int i = 0; i < 40; i++) begin
            rd1 = 1'(rand_bits(1));
            rd2 = 1'(rand_bits(1));
            a1  = waddr_t'(rand_bits(8));
            a2  = waddr_t'(rand_bits(8));
            s1  = rand_sel();
            s2  = rand_sel();
            issue_instr(1'b0, 1'b0, rd1, rd2, a1, a2, '0, s1, s2);
        end
        wait_outputs();

        test_name = "rep_step";
        for (int i = 0; i < 16; i++) begin
            dec = 1'(rand_bits(1));
            cnt = rep_cnt_t'(rand_range(0, 6, 3));
            a1  = waddr_t'(rand_bits(8));
            a2  = waddr_t'(rand_bits(8));
            issue_instr(1'b1, dec, 1'b1, 1'b1, a1, a2, cnt, SRC_MEM1, SRC_MEM2);
            wait_outputs();
            @(negedge clk);
            check_value("stall after last pulse", 64'(0), 64'(stall));
        end

        // reads stay in the lower half while writes only hit the upper half
        test_name = "contention";
        for (int i = 0; i < 12; i++) begin
            dec = 1'(rand_bits(1));
            cnt = rep_cnt_t'(rand_range(1, 6, 3));
            a1  = waddr_t'(rand_range(8, 119, 7));
            a2  = waddr_t'(rand_range(8, 119, 7));
            issue_instr(1'b1, dec, 1'b1, 1'b1, a1, a2, cnt, SRC_MEM2, SRC_MEM1);
            for (int j = 0; j < 3; j++) begin
                send_write(waddr_t'(rand_range(128, 255, 7)), rand_bits(64));
            end
            wait_wb_free();
        end
        wait_outputs();
        wait_stall_low();

        $display("Test completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

//--- build.f
+incdir+hw
hw/mem_pkg.sv
hw/rep_addr_gen.sv
hw/mem_read_port.sv
hw/mem_arbiter.sv
hw/data_mem.sv
hw/operand_select.sv
hw/mem_stage.sv
test/tb_mem_stage.sv

//--- run.sh
#!/bin/sh
# compile with verilator, run, then decide on the log contents
rm -f build.log sim.log

verilator --binary --timing -Wno-fatal --top-module tb_mem_stage \
    -f build.f -o tb_mem_stage > build.log 2>&1 \
    || { cat build.log; echo "compile step failed"; exit 1; }

./obj_dir/tb_mem_stage > sim.log 2>&1 || true
cat sim.log

grep -q "Test failed" sim.log && { echo "simulation reported failure"; exit 1; }
grep -q "Test completed successfully" sim.log || { echo "simulation did not finish"; exit 1; }
exit 0
